//--- source/mic_debug_config.svh
// Constants for the microphone debug front end clocking, blocks and message timing
`ifndef MIC_DEBUG_CONFIG_SVH
`define MIC_DEBUG_CONFIG_SVH

// ------------------------------------------------------------
// I2S microphone
// ------------------------------------------------------------
`define MIC_SCK_HALF_CYCLES 2       // clk cycles per half bit clock
`define MIC_BITS_PER_FRAME  64      // Left plus right slots
`define MIC_SAMPLE_BITS     24      // Audio sample width

// ------------------------------------------------------------
// Peak reporting
// ------------------------------------------------------------
`define PEAK_BLOCK_FRAMES   16      // Frames per peak block
`define PEAK_MARKER         8'h50   // Packet start, ASCII P

// ------------------------------------------------------------
// UART and debug message
// ------------------------------------------------------------
`define UART_CLKS_PER_BIT   8       // clk cycles per serial bit
`define DEBUG_GAP_CYCLES    16      // Idle cycles after each debug byte
`define BTN_SYNC_STAGES     3       // Button synchronizer depth

`endif

//--- source/mic_debug_pkg.sv
// Shared vector types and sequencer state encoding for the microphone debug front end
`include "mic_debug_config.svh"

package mic_debug_pkg;

    // Signed audio sample, also used for peak magnitudes
    typedef logic signed [`MIC_SAMPLE_BITS-1:0] sample_t;

    typedef logic [7:0] byte_t;     // One UART payload byte
    typedef logic [5:0] led_t;      // Six board LEDs

    // Debug message sequencer
    typedef enum logic [1:0] {
        IDLE,                       // Waiting for button edge
        REQUEST,                    // Byte offered to arbiter
        GAP                         // Pause after a taken byte
    } debug_state_t;

endpackage

//--- source/i2s_master_rx.sv
// I2S master receiver making bit clock and word select and capturing left samples
`timescale 1ns/1ps
`include "mic_debug_config.svh"

module i2s_master_rx (
    input  logic                  clk,
    input  logic                  resetb,
    input  logic                  sd_i,
    output logic                  sck_o,
    output logic                  ws_o,
    output mic_debug_pkg::sample_t sample_o,
    output logic                  sample_valid_o
);

    localparam int HALF_W  = $clog2(`MIC_SCK_HALF_CYCLES + 1);
    localparam int FRAME_W = $clog2(`MIC_BITS_PER_FRAME);

    localparam logic [HALF_W-1:0]  HALF_LAST = HALF_W'(`MIC_SCK_HALF_CYCLES - 1);
    localparam logic [FRAME_W-1:0] BIT_LAST  = FRAME_W'(`MIC_BITS_PER_FRAME - 1);
    localparam logic [FRAME_W-1:0] RIGHT_POS = FRAME_W'(`MIC_BITS_PER_FRAME / 2);
    localparam logic [FRAME_W-1:0] LSB_POS   = FRAME_W'(`MIC_SAMPLE_BITS);

    logic [HALF_W-1:0]      half_cnt_q;
    logic [FRAME_W-1:0]     bit_cnt_q;      // Falling edges since ws fell
    logic [FRAME_W-1:0]     bit_cnt_nxt;
    logic                   half_end;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   left_bit;
    logic                   lsb_q;          // LSB just shifted in
    mic_debug_pkg::sample_t shift_q;

    assign half_end    = (half_cnt_q == HALF_LAST);
    assign sck_rise    = half_end & ~sck_o;
    assign sck_fall    = half_end & sck_o;
    assign bit_cnt_nxt = (bit_cnt_q == BIT_LAST) ? '0 : bit_cnt_q + 1'b1;

    // Slot 0 is the one-bit I2S delay, slots 1..24 carry the left sample
    assign left_bit = (bit_cnt_q != '0) && (bit_cnt_q <= LSB_POS);

    // ------------------------------------------------------------
    // Bit clock and word select
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            half_cnt_q <= '0;
            sck_o      <= 1'b0;
            ws_o       <= 1'b0;             // Left half first
            bit_cnt_q  <= '0;
        end else begin
            if (half_end) begin
                half_cnt_q <= '0;
                sck_o      <= ~sck_o;
            end else begin
                half_cnt_q <= half_cnt_q + 1'b1;
            end
            if (sck_fall) begin             // ws moves on falling sck only
                bit_cnt_q <= bit_cnt_nxt;
                ws_o      <= (bit_cnt_nxt >= RIGHT_POS);
            end
        end
    end

    // ------------------------------------------------------------
    // Left sample capture
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (sck_rise && left_bit) begin
            shift_q <= {shift_q[`MIC_SAMPLE_BITS-2:0], sd_i};   // MSB first
        end
    end

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            lsb_q          <= 1'b0;
            sample_valid_o <= 1'b0;
        end else begin
            lsb_q          <= sck_rise && (bit_cnt_q == LSB_POS);
            sample_valid_o <= lsb_q;        // One clk after the LSB edge
        end
    end

    // Held until slot 1 of the next frame
    assign sample_o = shift_q;

endmodule

//--- source/peak_reporter.sv
// Block peak magnitude tracker with LED display and two-byte UART packet request
`timescale 1ns/1ps
`include "mic_debug_config.svh"

module peak_reporter (
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   sample_valid_i,
    input  mic_debug_pkg::sample_t sample_i,
    output logic                   req_o,
    output mic_debug_pkg::byte_t   data_o,
    input  logic                   taken_i,
    output mic_debug_pkg::led_t    led_o
);

    localparam int FRAME_W = $clog2(`PEAK_BLOCK_FRAMES);
    localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(`PEAK_BLOCK_FRAMES - 1);

    localparam mic_debug_pkg::sample_t MOST_NEG = {1'b1, {(`MIC_SAMPLE_BITS-1){1'b0}}};
    localparam mic_debug_pkg::sample_t MAX_POS  = {1'b0, {(`MIC_SAMPLE_BITS-1){1'b1}}};

    mic_debug_pkg::sample_t mag;
    mic_debug_pkg::sample_t max_q;          // Running block maximum
    mic_debug_pkg::sample_t block_max;
    mic_debug_pkg::byte_t   peak_q;
    logic [FRAME_W-1:0]     frame_cnt_q;
    logic                   second_q;       // Marker sent, peak byte next
    logic                   block_end;

    // Absolute value, most negative code saturates
    always_comb begin
        if (sample_i == MOST_NEG) begin
            mag = MAX_POS;
        end else if (sample_i[`MIC_SAMPLE_BITS-1]) begin
            mag = -sample_i;
        end else begin
            mag = sample_i;
        end
    end

    assign block_max = (mag > max_q) ? mag : max_q;
    assign block_end = sample_valid_i && (frame_cnt_q == FRAME_LAST);

    // ------------------------------------------------------------
    // Block tracking and packet request
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            max_q       <= '0;
            frame_cnt_q <= '0;
            req_o       <= 1'b0;
            second_q    <= 1'b0;
            led_o       <= '0;
        end else begin
            if (taken_i) begin
                if (second_q) begin         // Packet done
                    req_o    <= 1'b0;
                    second_q <= 1'b0;
                end else begin
                    second_q <= 1'b1;
                end
            end
            if (block_end) begin
                max_q       <= '0;          // Fresh block
                frame_cnt_q <= '0;
                req_o       <= 1'b1;        // Overrides a drop in the same cycle
                led_o       <= block_max[22:17];
            end else if (sample_valid_i) begin
                max_q       <= block_max;
                frame_cnt_q <= frame_cnt_q + 1'b1;
            end
        end
    end

    // Newer peak replaces a pending one
    always_ff @(posedge clk) begin
        if (block_end) begin
            peak_q <= block_max[22:15];
        end
    end

    assign data_o = second_q ? peak_q : `PEAK_MARKER;

endmodule

//--- source/debug_sequencer.sv
// Button-started sequencer that sends the fixed debug message byte by byte
`timescale 1ns/1ps
`include "mic_debug_config.svh"

module debug_sequencer (
    input  logic                 clk,
    input  logic                 resetb,
    input  logic                 btn_i,
    output logic                 req_o,
    output mic_debug_pkg::byte_t data_o,
    input  logic                 taken_i
);

    localparam int IDX_W = 5;
    localparam int GAP_W = $clog2(`DEBUG_GAP_CYCLES);

    localparam logic [IDX_W-1:0] IDX_LAST   = IDX_W'(22);     // 23 bytes
    localparam logic [IDX_W-1:0] IDX_HEX0   = IDX_W'(5);      // First counted byte
    localparam logic [GAP_W-1:0] GAP_LAST   = GAP_W'(`DEBUG_GAP_CYCLES - 1);

    logic [`BTN_SYNC_STAGES-1:0] btn_sync_q;
    logic                        btn_prev_q;
    logic                        btn_rise;
    logic [IDX_W-1:0]            idx_q;
    logic [GAP_W-1:0]            gap_cnt_q;
    mic_debug_pkg::debug_state_t state_q;

    // ------------------------------------------------------------
    // Button synchronizer and rising edge
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            btn_sync_q <= '0;
            btn_prev_q <= 1'b0;
        end else begin
            btn_sync_q <= {btn_sync_q[`BTN_SYNC_STAGES-2:0], btn_i};
            btn_prev_q <= btn_sync_q[`BTN_SYNC_STAGES-1];
        end
    end

    // True low to high only
    assign btn_rise = btn_sync_q[`BTN_SYNC_STAGES-1] & ~btn_prev_q;

    // ------------------------------------------------------------
    // Message FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            state_q   <= mic_debug_pkg::IDLE;
            idx_q     <= '0;
            gap_cnt_q <= '0;
        end else begin
            case (state_q)
                mic_debug_pkg::IDLE: begin
                    if (btn_rise) begin
                        state_q <= mic_debug_pkg::REQUEST;
                        idx_q   <= '0;
                    end
                end
                mic_debug_pkg::REQUEST: begin
                    if (taken_i) begin
                        state_q   <= mic_debug_pkg::GAP;
                        gap_cnt_q <= '0;
                    end
                end
                mic_debug_pkg::GAP: begin
                    gap_cnt_q <= gap_cnt_q + 1'b1;
                    if (gap_cnt_q == GAP_LAST) begin
                        if (idx_q == IDX_LAST) begin
                            state_q <= mic_debug_pkg::IDLE;     // Message done
                        end else begin
                            state_q <= mic_debug_pkg::REQUEST;
                            idx_q   <= idx_q + 1'b1;
                        end
                    end
                end
                default: state_q <= mic_debug_pkg::IDLE;
            endcase
        end
    end

    assign req_o = (state_q == mic_debug_pkg::REQUEST);

    // "DBG: ", 0x00 to 0x0F, CR LF
    always_comb begin
        case (idx_q)
            5'd0:    data_o = 8'h44;        // D
            5'd1:    data_o = 8'h42;        // B
            5'd2:    data_o = 8'h47;        // G
            5'd3:    data_o = 8'h3A;        // Colon
            5'd4:    data_o = 8'h20;        // Space
            5'd21:   data_o = 8'h0D;        // CR
            5'd22:   data_o = 8'h0A;        // LF
            default: data_o = mic_debug_pkg::byte_t'(idx_q - IDX_HEX0);
        endcase
    end

endmodule

//--- source/uart_tx_arbiter.sv
// Two-way arbiter sharing the UART transmitter with packet-long grants
`timescale 1ns/1ps

module uart_tx_arbiter (
    input  logic                 clk,
    input  logic                 resetb,
    input  logic                 peak_req_i,
    input  logic                 dbg_req_i,
    input  mic_debug_pkg::byte_t peak_data_i,
    input  mic_debug_pkg::byte_t dbg_data_i,
    output logic                 peak_taken_o,
    output logic                 dbg_taken_o,
    input  logic                 tx_busy_i,
    output logic                 tx_start_o,
    output mic_debug_pkg::byte_t tx_data_o
);

    logic locked_q;                 // Grant held
    logic owner_dbg_q;              // Holder is the debug sequencer
    logic sel_dbg;
    logic sel_req;

    // Peak reporter wins when free
    assign sel_dbg = locked_q ? owner_dbg_q : ~peak_req_i;
    assign sel_req = sel_dbg ? dbg_req_i : peak_req_i;

    assign tx_start_o   = sel_req & ~tx_busy_i;
    assign tx_data_o    = sel_dbg ? dbg_data_i : peak_data_i;
    assign peak_taken_o = tx_start_o & ~sel_dbg;
    assign dbg_taken_o  = tx_start_o & sel_dbg;

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            locked_q    <= 1'b0;
            owner_dbg_q <= 1'b0;
        end else if (tx_start_o) begin
            locked_q    <= 1'b1;
            owner_dbg_q <= sel_dbg;
        end else if (locked_q && !sel_req) begin
            locked_q    <= 1'b0;    // Holder dropped its request
        end
    end

endmodule

//--- source/uart_tx.sv
// 8N1 UART transmitter, LSB first, with busy level
`timescale 1ns/1ps
`include "mic_debug_config.svh"

module uart_tx (
    input  logic                 clk,
    input  logic                 resetb,
    input  logic                 start_i,
    input  mic_debug_pkg::byte_t data_i,
    output logic                 busy_o,
    output logic                 tx_o
);

    localparam int CLK_W = $clog2(`UART_CLKS_PER_BIT + 1);
    localparam logic [CLK_W-1:0] CLK_LAST = CLK_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [3:0]       BIT_STOP = 4'd9;

    logic [CLK_W-1:0] clk_cnt_q;    // Position inside one bit
    logic [3:0]       bit_cnt_q;    // 0 start, 1..8 data, 9 stop
    logic [8:0]       shift_q;      // Data bits then stop bit

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            busy_o    <= 1'b0;
            tx_o      <= 1'b1;      // Line idle
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                busy_o    <= 1'b1;
                tx_o      <= 1'b0;  // Start bit
                clk_cnt_q <= '0;
                bit_cnt_q <= '0;
            end
        end else if (clk_cnt_q == CLK_LAST) begin
            clk_cnt_q <= '0;
            if (bit_cnt_q == BIT_STOP) begin
                busy_o <= 1'b0;     // Stop bit complete
            end else begin
                tx_o      <= shift_q[0];
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    // Frame payload
    always_ff @(posedge clk) begin
        if (!busy_o && start_i) begin
            shift_q <= {1'b1, data_i};
        end else if (busy_o && clk_cnt_q == CLK_LAST) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

endmodule

//--- source/mic_debug_top.sv
// Microphone debug front end top level with I2S capture, peak packets and debug message
`timescale 1ns/1ps

module mic_debug_top (
    input  logic                clk,
    input  logic                resetb,
    input  logic                mic_sd_i,
    input  logic                btn_debug_i,
    output logic                mic_sck_o,
    output logic                mic_ws_o,
    output logic                uart_tx_o,
    output mic_debug_pkg::led_t debug_led_o
);

    mic_debug_pkg::sample_t sample;
    logic                   sample_valid;
    logic                   peak_req;
    logic                   peak_taken;
    mic_debug_pkg::byte_t   peak_data;
    logic                   dbg_req;
    logic                   dbg_taken;
    mic_debug_pkg::byte_t   dbg_data;
    logic                   tx_start;
    logic                   tx_busy;
    mic_debug_pkg::byte_t   tx_data;

    // ------------------------------------------------------------
    // Audio path
    // ------------------------------------------------------------
    i2s_master_rx i_i2s_rx (
        .clk            (clk),
        .resetb         (resetb),
        .sd_i           (mic_sd_i),
        .sck_o          (mic_sck_o),
        .ws_o           (mic_ws_o),
        .sample_o       (sample),
        .sample_valid_o (sample_valid)
    );

    peak_reporter i_peak (
        .clk            (clk),
        .resetb         (resetb),
        .sample_valid_i (sample_valid),
        .sample_i       (sample),
        .req_o          (peak_req),
        .data_o         (peak_data),
        .taken_i        (peak_taken),
        .led_o          (debug_led_o)
    );

    // ------------------------------------------------------------
    // Debug message and shared UART
    // ------------------------------------------------------------
    debug_sequencer i_dbg_seq (
        .clk     (clk),
        .resetb  (resetb),
        .btn_i   (btn_debug_i),
        .req_o   (dbg_req),
        .data_o  (dbg_data),
        .taken_i (dbg_taken)
    );

    uart_tx_arbiter i_arb (
        .clk          (clk),
        .resetb       (resetb),
        .peak_req_i   (peak_req),
        .dbg_req_i    (dbg_req),
        .peak_data_i  (peak_data),
        .dbg_data_i   (dbg_data),
        .peak_taken_o (peak_taken),
        .dbg_taken_o  (dbg_taken),
        .tx_busy_i    (tx_busy),
        .tx_start_o   (tx_start),
        .tx_data_o    (tx_data)
    );

    uart_tx i_uart_tx (
        .clk     (clk),
        .resetb  (resetb),
        .start_i (tx_start),
        .data_i  (tx_data),
        .busy_o  (tx_busy),
        .tx_o    (uart_tx_o)
    );

endmodule

//--- tb/tb_checker.sv
// Testbench checker decoding the UART line and comparing bytes with the expected queues
`timescale 1ns/1ps
`include "mic_debug_config.svh"

module tb_checker (
    input logic                clk,
    input logic                resetb,
    input logic                uart_tx_i,
    input logic                mic_sck_i,
    input logic                mic_ws_i,
    input mic_debug_pkg::led_t debug_led_i
);

    mic_debug_pkg::byte_t peak_exp_q [$];       // Block peak bytes in order
    mic_debug_pkg::led_t  led_exp_q [$];
    mic_debug_pkg::byte_t dbg_exp_q [$];        // Debug message bytes

    int                   value_errors = 0;
    int                   frame_errors = 0;
    int                   seq_errors   = 0;
    logic                 rx_active    = 1'b0;  // Inside a UART frame
    logic                 peak_next    = 1'b0;  // Value byte follows a marker
    int                   rx_cnt;
    mic_debug_pkg::byte_t rx_byte;

    task automatic push_peak(input mic_debug_pkg::byte_t peak, input mic_debug_pkg::led_t led);
        peak_exp_q.push_back(peak);
        led_exp_q.push_back(led);
    endtask

    task automatic push_debug(input mic_debug_pkg::byte_t b);
        dbg_exp_q.push_back(b);
    endtask

    function automatic int debug_pending();
        return dbg_exp_q.size();
    endfunction

    function automatic bit drained();
        return (peak_exp_q.size() == 0) && (led_exp_q.size() == 0) &&
               (dbg_exp_q.size() == 0) && !rx_active && !peak_next;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        value_errors++;
        $display("error at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
    endtask

    // Reset levels sampled mid-cycle
    always @(negedge clk) begin
        if (!resetb) begin
            if (uart_tx_i !== 1'b1) report_value("uart_tx_o", 32'h1, 32'(uart_tx_i));
            if (mic_sck_i !== 1'b0) report_value("mic_sck_o", 32'h0, 32'(mic_sck_i));
            if (mic_ws_i !== 1'b0) report_value("mic_ws_o", 32'h0, 32'(mic_ws_i));
            if (debug_led_i !== '0) report_value("debug_led_o", 32'h0, 32'(debug_led_i));
        end
    end

    // ------------------------------------------------------------
    // Byte classification
    // ------------------------------------------------------------
    task automatic handle_byte(input mic_debug_pkg::byte_t b);
        if (peak_next) begin
            peak_next = 1'b0;
            if (peak_exp_q.size() == 0) begin
                seq_errors++;
                $display("Peak value %0h at %0d ns with no block peak expected", b, $time);
            end else if (b !== peak_exp_q[0]) begin
                report_value("uart_tx_o peak value", 32'(peak_exp_q.pop_front()), 32'(b));
            end else begin
                void'(peak_exp_q.pop_front());
            end
        end else if (b == `PEAK_MARKER) begin
            peak_next = 1'b1;
            if (led_exp_q.size() == 0) begin
                seq_errors++;
                $display("Peak marker at %0d ns with no block peak expected", $time);
            end else if (debug_led_i !== led_exp_q[0]) begin
                report_value("debug_led_o", 32'(led_exp_q.pop_front()), 32'(debug_led_i));
            end else begin
                void'(led_exp_q.pop_front());
            end
        end else if (dbg_exp_q.size() == 0) begin
            seq_errors++;
            $display("Unexpected byte %0h at %0d ns outside any debug message", b, $time);
        end else if (b !== dbg_exp_q[0]) begin
            report_value("uart_tx_o debug byte", 32'(dbg_exp_q.pop_front()), 32'(b));
        end else begin
            void'(dbg_exp_q.pop_front());
        end
    endtask

    // ------------------------------------------------------------
    // UART decoder sampling each bit at mid-bit
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!resetb) begin
            rx_active = 1'b0;
        end else if (!rx_active) begin
            if (!uart_tx_i) begin           // First cycle of a start bit
                rx_active = 1'b1;
                rx_cnt    = 0;
            end
        end else begin
            rx_cnt++;
            if ((rx_cnt % `UART_CLKS_PER_BIT) == `UART_CLKS_PER_BIT / 2) begin
                case (rx_cnt / `UART_CLKS_PER_BIT)
                    0: begin
                        if (uart_tx_i !== 1'b0) begin
                            frame_errors++;
                            rx_active = 1'b0;
                            $display("Start bit at %0d ns did not last to mid-bit", $time);
                        end
                    end
                    9: begin
                        rx_active = 1'b0;
                        if (uart_tx_i !== 1'b1) begin
                            frame_errors++;
                            $display("error at %0d ns: uart_tx_o stop bit expected 1 got %b",
                                     $time, uart_tx_i);
                        end
                        handle_byte(rx_byte);
                    end
                    default: rx_byte[rx_cnt / `UART_CLKS_PER_BIT - 1] = uart_tx_i;  // LSB first
                endcase
            end
        end
    end

    task automatic final_check();
        if (led_exp_q.size() != 0 || peak_exp_q.size() != 0) begin
            seq_errors++;
            $display("%0d expected peak packets never arrived", led_exp_q.size());
        end
        if (dbg_exp_q.size() != 0) begin
            seq_errors++;
            $display("%0d expected debug bytes never arrived", dbg_exp_q.size());
        end
        if (rx_active || peak_next) begin
            seq_errors++;
            $display("UART traffic still in progress when the test ended");
        end
    endtask

endmodule

//--- tb/tb_mic_debug_top.sv
// Testbench for the microphone debug front end with I2S microphone model and button presses
`timescale 1ns/1ps
`include "mic_debug_config.svh"

module tb_clock_gen (
    output logic clk_o
);

    localparam realtime HALF_PERIOD = 4.0;     // 8 ns period

    initial clk_o = 1'b0;
    always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

module tb_mic_debug_top;

    localparam int          BLOCKS      = 8;    // Peak blocks streamed
    localparam int          PRESSES     = 10;
    localparam int          DRAIN_LIMIT = 6000;
    localparam logic [31:0] SEED        = 32'h5fd8_3ef9;
    localparam logic [31:0] LFSR_MASK   = 32'h8020_0003;   // Taps 32 22 2 1

    logic                clk;
    logic                resetb;
    logic                mic_sd;
    logic                btn_debug;
    logic                mic_sck;
    logic                mic_ws;
    logic                uart_tx;
    mic_debug_pkg::led_t debug_led;
    logic [31:0]         lfsr;
    int                  timeout_count;
    int                  press_gap [PRESSES];
    int                  press_len [PRESSES];

    tb_clock_gen i_clk_gen (.clk_o(clk));

    mic_debug_top i_dut (
        .clk         (clk),
        .resetb      (resetb),
        .mic_sd_i    (mic_sd),
        .btn_debug_i (btn_debug),
        .mic_sck_o   (mic_sck),
        .mic_ws_o    (mic_ws),
        .uart_tx_o   (uart_tx),
        .debug_led_o (debug_led)
    );

    tb_checker i_checker (
        .clk         (clk),
        .resetb      (resetb),
        .uart_tx_i   (uart_tx),
        .mic_sck_i   (mic_sck),
        .mic_ws_i    (mic_ws),
        .debug_led_i (debug_led)
    );

    // ------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------
    function automatic logic rand_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = (lfsr >> 1) ^ (lsb ? LFSR_MASK : 32'h0);    // Galois step
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // Full-scale negative clips to full-scale positive
    function automatic logic [23:0] magnitude(input logic [23:0] s);
        if (s == 24'h80_0000) return 24'h7F_FFFF;
        if (s[23]) return -s;
        return s;
    endfunction

    // Expected debug message "DBG: " then 0x00..0x0F then CR LF
    function automatic logic [7:0] msg_byte(input int idx);
        string head;
        head = "DBG: ";
        if (idx < 5) return head[idx];
        if (idx < 21) return 8'(idx - 5);     // Counting bytes
        if (idx == 21) return 8'h0D;
        return 8'h0A;
    endfunction

    // ------------------------------------------------------------
    // Microphone and button
    // ------------------------------------------------------------
    task automatic wait_sck_fall(output bit ok);
        logic prev;
        int   n;
        prev = mic_sck;
        ok   = 1'b0;
        n    = 0;
        while (!ok && n < 4 * `MIC_SCK_HALF_CYCLES + 4) begin
            @(posedge clk);
            #1;
            ok   = prev & ~mic_sck;
            prev = mic_sck;
            n++;
        end
        if (!ok) begin
            timeout_count++;
            $display("Timeout at %0d ns, bit clock stopped toggling", $time);
        end
    endtask

    task automatic mic_stream();
        logic signed [23:0] sample;
        logic [23:0]        peak;
        bit                 ok;
        int                 blk;
        int                 frm;
        int                 slot;
        int                 shift;
        for (blk = 0; blk < BLOCKS; blk++) begin
            peak = '0;
            for (frm = 0; frm < `PEAK_BLOCK_FRAMES; frm++) begin
                sample = 24'(rand_bits(24));
                shift  = int'(rand_bits(3));                // Spread block peaks
                sample = sample >>> shift;
                if (rand_bits(4) == 0) sample = 24'h80_0000;
                if (magnitude(sample) > peak) peak = magnitude(sample);
                // Slot 64 is the delay slot of the next frame
                for (slot = 1; slot <= `MIC_BITS_PER_FRAME; slot++) begin
                    wait_sck_fall(ok);
                    if (!ok) return;
                    if (slot <= `MIC_SAMPLE_BITS) mic_sd = sample[`MIC_SAMPLE_BITS - slot];
                    else mic_sd = rand_bit();              // Right half and delay slot
                    if (slot == `MIC_SAMPLE_BITS && frm == `PEAK_BLOCK_FRAMES - 1) begin
                        i_checker.push_peak(peak[22:15], peak[22:17]);
                    end
                end
            end
        end
        mic_sd = 1'b0;
    endtask

    task automatic button_presses();
        int i;
        int n;
        for (i = 0; i < PRESSES; i++) begin
            repeat (press_gap[i]) @(posedge clk);
            #1;
            if (i_checker.debug_pending() == 0) begin
                for (n = 0; n < 23; n++) begin
                    i_checker.push_debug(msg_byte(n));
                end
            end else if (i_checker.debug_pending() < 3) begin
                continue;                   // Sequencer may be finishing its last byte
            end
            btn_debug = 1'b1;
            repeat (press_len[i]) @(posedge clk);
            #1;
            btn_debug = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (!i_checker.drained() && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!i_checker.drained()) begin
            timeout_count++;
            $display("Timeout at %0d ns, expected UART bytes still missing", $time);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int i;
        int total;
        mic_sd        = 1'b0;
        btn_debug     = 1'b0;
        resetb        = 1'b0;
        lfsr          = SEED;
        timeout_count = 0;
        for (i = 0; i < PRESSES; i++) begin            // Press schedule drawn up front
            press_gap[i] = 64 + int'(rand_bits(11));
            press_len[i] = 1 + int'(rand_bits(5));
        end
        repeat (5) @(posedge clk);
        #1;
        resetb = 1'b1;
        fork
            mic_stream();
            button_presses();
        join
        if (timeout_count == 0) wait_drained();
        if (timeout_count == 0) begin
            repeat (200) @(posedge clk);                // Room for stray bytes
            i_checker.final_check();
        end
        total = i_checker.value_errors + i_checker.frame_errors +
                i_checker.seq_errors + timeout_count;
        $display("Error counts: value %0d, framing %0d, sequence %0d, timeout %0d",
                 i_checker.value_errors, i_checker.frame_errors,
                 i_checker.seq_errors, timeout_count);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- mic_debug_top.f
+incdir+source
source/mic_debug_pkg.sv
source/i2s_master_rx.sv
source/peak_reporter.sv
source/debug_sequencer.sv
source/uart_tx_arbiter.sv
source/uart_tx.sv
source/mic_debug_top.sv
tb/tb_checker.sv
tb/tb_mic_debug_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_mic_debug_top
FILELIST  := mic_debug_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
